// ==== ps2_pkg.sv ====
package ps2_pkg;

    typedef logic [7:0] scan_code_t;

    localparam int FRAME_BITS = 11;                 // start, 8 data, parity, stop
    localparam scan_code_t BREAK_PREFIX = 8'hF0;

    // set-2 make codes, upper case letters and digits only
    function automatic logic [7:0] scan_to_ascii(input scan_code_t sc);
        logic [7:0] asc;
        case (sc)
            8'h1C: asc = 8'h41; // A
            8'h32: asc = 8'h42;
            8'h21: asc = 8'h43;
            8'h23: asc = 8'h44;
            8'h24: asc = 8'h45;
            8'h2B: asc = 8'h46;
            8'h34: asc = 8'h47;
            8'h33: asc = 8'h48;
            8'h43: asc = 8'h49;
            8'h3B: asc = 8'h4A;
            8'h42: asc = 8'h4B;
            8'h4B: asc = 8'h4C;
            8'h3A: asc = 8'h4D;
            8'h31: asc = 8'h4E;
            8'h44: asc = 8'h4F;
            8'h4D: asc = 8'h50;
            8'h15: asc = 8'h51;
            8'h2D: asc = 8'h52;
            8'h1B: asc = 8'h53;
            8'h2C: asc = 8'h54;
            8'h3C: asc = 8'h55;
            8'h2A: asc = 8'h56;
            8'h1D: asc = 8'h57;
            8'h22: asc = 8'h58;
            8'h35: asc = 8'h59;
            8'h1A: asc = 8'h5A; // Z
            8'h45: asc = 8'h30; // 0
            8'h16: asc = 8'h31;
            8'h1E: asc = 8'h32;
            8'h26: asc = 8'h33;
            8'h25: asc = 8'h34;
            8'h2E: asc = 8'h35;
            8'h36: asc = 8'h36;
            8'h3D: asc = 8'h37;
            8'h3E: asc = 8'h38;
            8'h46: asc = 8'h39; // 9
            8'h29: asc = 8'h20; // space
            default: asc = 8'h00;
        endcase
        return asc;
    endfunction

endpackage

// ==== disp_pkg.sv ====
package disp_pkg;

    // active low, bit 6 is segment a, bit 0 is segment g
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_BLANK = 7'b1111111;

    function automatic seg_t hex_to_seg(input logic [3:0] val);
        seg_t seg;
        case (val)
            4'h0: seg = 7'b0000001;
            4'h1: seg = 7'b1001111;
            4'h2: seg = 7'b0010010;
            4'h3: seg = 7'b0000110;
            4'h4: seg = 7'b1001100;
            4'h5: seg = 7'b0100100;
            4'h6: seg = 7'b0100000;
            4'h7: seg = 7'b0001111;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0000100;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b1100000; // lower case b
            4'hC: seg = 7'b0110001;
            4'hD: seg = 7'b1000010; // lower case d
            4'hE: seg = 7'b0110000;
            default: seg = 7'b0111000; // F
        endcase
        return seg;
    endfunction

    function automatic seg_t dec_to_seg(input logic [3:0] val);
        seg_t seg;
        if (val > 4'd9)
            seg = SEG_BLANK;
        else
            seg = hex_to_seg(val);
        return seg;
    endfunction

endpackage

// ==== ps2_frame_rx.sv ====
`timescale 1ns/10ps

module ps2_frame_rx #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 credit_ret,
    output logic                 push,
    output ps2_pkg::scan_code_t  push_code,
    output logic                 overflow,
    output logic                 frame_error
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam logic [3:0] LAST_BIT = 4'(ps2_pkg::FRAME_BITS - 1);

    logic [2:0]                        clk_sync;  // two sync stages plus edge stage
    logic [1:0]                        data_sync;
    logic                              fall;
    logic [3:0]                        bit_cnt;
    logic [ps2_pkg::FRAME_BITS-1:0]    frame;
    logic                              frame_done;
    logic                              frame_ok;
    logic                              has_credit;
    logic [CW-1:0]                     credits;

    always_ff @(posedge clk) begin
        clk_sync  <= {clk_sync[1:0], ps2_clk};
        data_sync <= {data_sync[0], ps2_data};
    end

    assign fall = clk_sync[2] & ~clk_sync[1];

    // lsb first, so after the last bit frame[0] holds the start bit
    always_ff @(posedge clk) begin
        if (fall)
            frame <= {data_sync[1], frame[ps2_pkg::FRAME_BITS-1:1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // start low, odd parity over data and parity, stop high
    assign frame_ok   = ~frame[0] & (^frame[9:1]) & frame[10];
    assign has_credit = credits != '0;

    assign push      = frame_done & frame_ok & has_credit;
    assign push_code = frame[8:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            overflow    <= 1'b0;
            frame_error <= 1'b0;
        end else if (frame_done) begin
            if (!frame_ok)
                frame_error <= 1'b1;
            else if (!has_credit)
                overflow <= 1'b1;   // line can't stall, frame is lost
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(FIFO_DEPTH);
        end else begin
            case ({push, credit_ret})
                2'b10:   credits <= credits - CW'(1);
                2'b01:   credits <= credits + CW'(1);
                default: credits <= credits;   // none or both
            endcase
        end
    end

endmodule

// ==== scan_fifo.sv ====
`timescale 1ns/10ps

module scan_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  ps2_pkg::scan_code_t  push_code,
    input  logic                 pop,
    output ps2_pkg::scan_code_t  head_code,
    output logic                 head_valid,
    output logic                 credit_ret
);

    localparam int AW = $clog2(FIFO_DEPTH);

    ps2_pkg::scan_code_t  mem [FIFO_DEPTH];
    logic [AW:0]          wr_ptr;   // extra bit tells full from empty
    logic [AW:0]          rd_ptr;
    logic                 do_pop;

    assign do_pop = pop & head_valid;

    // no full check, sender holds one credit per free slot
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr[AW-1:0]] <= push_code;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr     <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= do_pop;   // slot freed, hand credit back
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // show-ahead head
    assign head_valid = wr_ptr != rd_ptr;
    assign head_code  = mem[rd_ptr[AW-1:0]];

endmodule

// ==== key_display.sv ====
`timescale 1ns/10ps

module key_display (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 next_key,
    input  ps2_pkg::scan_code_t  head_code,
    input  logic                 head_valid,
    output logic                 pop,
    output ps2_pkg::scan_code_t  code,
    output logic [7:0]           key_count,
    output disp_pkg::seg_t       seg0,
    output disp_pkg::seg_t       seg1,
    output disp_pkg::seg_t       seg2,
    output disp_pkg::seg_t       seg3,
    output disp_pkg::seg_t       seg4,
    output disp_pkg::seg_t       seg5
);

    localparam logic [7:0] COUNT_MAX = 8'd99;

    logic        brk;         // F0 seen, next code is a release
    logic [7:0]  ascii;
    logic [7:0]  ascii_mod;
    logic [3:0]  ascii_tens;
    logic [3:0]  ascii_units;
    logic [3:0]  cnt_tens;
    logic [3:0]  cnt_units;

    // requests while empty are simply dropped
    assign pop = next_key & head_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            code      <= 8'h00;
            key_count <= 8'd0;
            brk       <= 1'b0;
        end else if (pop) begin
            code <= head_code;
            if (brk) begin
                brk <= 1'b0;   // release code, not a press
            end else if (head_code == ps2_pkg::BREAK_PREFIX) begin
                brk <= 1'b1;
            end else if (key_count != COUNT_MAX) begin
                key_count <= key_count + 8'd1;
            end
        end
    end

    assign ascii       = ps2_pkg::scan_to_ascii(code);
    assign ascii_mod   = ascii % 8'd100;
    assign ascii_tens  = 4'(ascii_mod / 8'd10);
    assign ascii_units = 4'(ascii_mod % 8'd10);

    assign cnt_tens  = 4'(key_count / 8'd10);
    assign cnt_units = 4'(key_count % 8'd10);

    // code in hex
    assign seg0 = disp_pkg::hex_to_seg(code[3:0]);
    assign seg1 = disp_pkg::hex_to_seg(code[7:4]);

    // ascii in decimal, dark for unmapped keys
    assign seg2 = (ascii == 8'h00) ? disp_pkg::SEG_BLANK : disp_pkg::dec_to_seg(ascii_units);
    assign seg3 = (ascii == 8'h00) ? disp_pkg::SEG_BLANK : disp_pkg::dec_to_seg(ascii_tens);

    assign seg4 = disp_pkg::dec_to_seg(cnt_units);
    assign seg5 = disp_pkg::dec_to_seg(cnt_tens);

endmodule

// ==== ps2_key_top.sv ====
`timescale 1ns/10ps

module ps2_key_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 next_key,
    output ps2_pkg::scan_code_t  code,
    output logic                 ready,
    output logic                 overflow,
    output logic                 frame_error,
    output logic [7:0]           key_count,
    output disp_pkg::seg_t       seg0,
    output disp_pkg::seg_t       seg1,
    output disp_pkg::seg_t       seg2,
    output disp_pkg::seg_t       seg3,
    output disp_pkg::seg_t       seg4,
    output disp_pkg::seg_t       seg5
);

    logic                 push;
    ps2_pkg::scan_code_t  push_code;
    logic                 credit_ret;
    logic                 pop;
    ps2_pkg::scan_code_t  head_code;
    logic                 head_valid;

    ps2_frame_rx #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .credit_ret  (credit_ret),
        .push        (push),
        .push_code   (push_code),
        .overflow    (overflow),
        .frame_error (frame_error)
    );

    scan_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_code  (push_code),
        .pop        (pop),
        .head_code  (head_code),
        .head_valid (head_valid),
        .credit_ret (credit_ret)
    );

    key_display i_disp (
        .clk        (clk),
        .rst        (rst),
        .next_key   (next_key),
        .head_code  (head_code),
        .head_valid (head_valid),
        .pop        (pop),
        .code       (code),
        .key_count  (key_count),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5)
    );

    assign ready = head_valid;

endmodule

// ==== tb_ps2_key_top.sv ====
`timescale 1ns/10ps

module tb_ps2_key_top;

    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int PHASE_CYCLES = 10;
    localparam int N_RANDOM     = 8;
    localparam int NUM_FRAMES   = N_RANDOM + 14;  // random run plus the directed frames
    localparam int FRAME_CYCLES = ps2_pkg::FRAME_BITS * 2 * PHASE_CYCLES + PHASE_CYCLES;
    localparam int TIMEOUT_NS   = NUM_FRAMES * FRAME_CYCLES * CLK_PERIOD * 2 + 4000;

    localparam ps2_pkg::scan_code_t KEY_CODES [36] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h45,
        8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    typedef disp_pkg::seg_t [5:0] seg_vec_t;

    logic                 clk;
    logic                 rst;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic                 next_key;
    ps2_pkg::scan_code_t  code;
    logic                 ready;
    logic                 overflow;
    logic                 frame_error;
    logic [7:0]           key_count;
    disp_pkg::seg_t       seg0, seg1, seg2, seg3, seg4, seg5;

    // reference model state
    ps2_pkg::scan_code_t  ref_q [$];
    ps2_pkg::scan_code_t  ref_code;
    logic [7:0]           ref_count;
    logic                 ref_brk;
    logic                 ref_overflow;
    logic                 ref_frame_error;

    logic [31:0]          rnd_state;
    logic                 cmp_en;
    seg_vec_t             exp_seg;
    int                   error_count;
    int                   check_total;

    ps2_key_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .next_key    (next_key),
        .code        (code),
        .ready       (ready),
        .overflow    (overflow),
        .frame_error (frame_error),
        .key_count   (key_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // all six digits for a shown code and press count
    function automatic seg_vec_t expected_segs(input ps2_pkg::scan_code_t c,
                                               input logic [7:0] cnt);
        seg_vec_t   s;
        logic [7:0] asc;
        logic [7:0] asc_mod;
        asc     = ps2_pkg::scan_to_ascii(c);
        asc_mod = asc % 8'd100;
        s[0]    = disp_pkg::hex_to_seg(c[3:0]);
        s[1]    = disp_pkg::hex_to_seg(c[7:4]);
        if (asc == 8'h00) begin
            s[2] = disp_pkg::SEG_BLANK;
            s[3] = disp_pkg::SEG_BLANK;
        end else begin
            s[2] = disp_pkg::dec_to_seg(4'(asc_mod % 8'd10));
            s[3] = disp_pkg::dec_to_seg(4'(asc_mod / 8'd10));
        end
        s[4] = disp_pkg::dec_to_seg(4'(cnt % 8'd10));
        s[5] = disp_pkg::dec_to_seg(4'(cnt / 8'd10));
        return s;
    endfunction

    task automatic check_code(input string name, input ps2_pkg::scan_code_t got,
                              input ps2_pkg::scan_code_t exp);
        check_total++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_seg(input string name, input disp_pkg::seg_t got,
                             input disp_pkg::seg_t exp);
        check_total++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        check_total++;
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // display outputs against the model on every falling clk edge
    always @(negedge clk) begin
        if (cmp_en) begin
            exp_seg = expected_segs(ref_code, ref_count);
            check_code("code", code, ref_code);
            check_count("key_count", key_count, ref_count);
            check_seg("seg0", seg0, exp_seg[0]);
            check_seg("seg1", seg1, exp_seg[1]);
            check_seg("seg2", seg2, exp_seg[2]);
            check_seg("seg3", seg3, exp_seg[3]);
            check_seg("seg4", seg4, exp_seg[4]);
            check_seg("seg5", seg5, exp_seg[5]);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pick_key_code(output ps2_pkg::scan_code_t c);
        rnd_state = xorshift32(rnd_state);
        c = KEY_CODES[int'(rnd_state % 32'd36)];
    endtask

    task automatic model_receive(input ps2_pkg::scan_code_t c, input logic bad);
        if (bad)
            ref_frame_error = 1'b1;
        else if (ref_q.size() >= FIFO_DEPTH)
            ref_overflow = 1'b1;    // no credit left
        else
            ref_q.push_back(c);
    endtask

    task automatic model_pop();
        ps2_pkg::scan_code_t c;
        if (ref_q.size() != 0) begin
            c        = ref_q.pop_front();
            ref_code = c;
            if (ref_brk)
                ref_brk = 1'b0;
            else if (c == ps2_pkg::BREAK_PREFIX)
                ref_brk = 1'b1;
            else if (ref_count != 8'd99)
                ref_count = ref_count + 8'd1;
        end
    endtask

    // start, data lsb first, odd parity, stop
    task automatic send_frame(input ps2_pkg::scan_code_t c, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^c) ^ bad_parity, c, 1'b0};
        for (int i = 0; i < ps2_pkg::FRAME_BITS; i++) begin
            ps2_data = bits[i];
            repeat (PHASE_CYCLES) next_cycle();
            ps2_clk = 1'b0;
            repeat (PHASE_CYCLES) next_cycle();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (PHASE_CYCLES) next_cycle();
        model_receive(c, bad_parity);
    endtask

    task automatic press_key();
        next_key = 1'b1;
        next_cycle();
        next_key = 1'b0;
        model_pop();
    endtask

    task automatic wait_ready(input int max_cycles);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < max_cycles) begin
            next_cycle();
            n++;
        end
        if (ready !== 1'b1) begin
            $display("%0t ready did not rise within %0d cycles after a frame", $time, max_cycles);
            error_count++;
        end
    endtask

    task automatic check_status();
        @(negedge clk);
        check_flag("ready", ready, ref_q.size() != 0);
        check_flag("overflow", overflow, ref_overflow);
        check_flag("frame_error", frame_error, ref_frame_error);
        next_cycle();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        ps2_pkg::scan_code_t c;
        clk             = 1'b0;
        rst             = 1'b1;
        ps2_clk         = 1'b1;
        ps2_data        = 1'b1;
        next_key        = 1'b0;
        cmp_en          = 1'b0;
        rnd_state       = 32'h16df_cf34;
        ref_code        = 8'h00;
        ref_count       = 8'd0;
        ref_brk         = 1'b0;
        ref_overflow    = 1'b0;
        ref_frame_error = 1'b0;
        error_count     = 0;
        check_total     = 0;
        repeat (2) @(posedge clk);
        #1;
        rst    = 1'b0;
        cmp_en = 1'b1;
        check_status();

        // one key at a time
        for (int i = 0; i < N_RANDOM; i++) begin
            pick_key_code(c);
            send_frame(c, 1'b0);
            wait_ready(4 * PHASE_CYCLES);
            press_key();
            check_status();
        end

        // fill the queue, then drain in order
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pick_key_code(c);
            send_frame(c, 1'b0);
        end
        check_status();
        for (int i = 0; i < FIFO_DEPTH; i++)
            press_key();
        check_status();

        // one frame more than the queue holds
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            pick_key_code(c);
            send_frame(c, 1'b0);
        end
        check_status();
        for (int i = 0; i <= FIFO_DEPTH; i++)
            press_key();
        check_status();

        // corrupted parity is dropped, a good frame still gets through
        pick_key_code(c);
        send_frame(c, 1'b1);
        check_status();
        pick_key_code(c);
        send_frame(c, 1'b0);
        wait_ready(4 * PHASE_CYCLES);
        press_key();
        check_status();

        // release sequence, then a plain press
        send_frame(ps2_pkg::BREAK_PREFIX, 1'b0);
        pick_key_code(c);
        send_frame(c, 1'b0);
        press_key();
        press_key();
        pick_key_code(c);
        send_frame(c, 1'b0);
        press_key();
        check_status();

        // requests with nothing queued
        repeat (3) press_key();
        check_status();

        repeat (4) next_cycle();
        cmp_en = 1'b0;
        $display("checks run: %0d, errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== ps2_key.f ====
ps2_pkg.sv
disp_pkg.sv
ps2_frame_rx.sv
scan_fifo.sv
key_display.sv
ps2_key_top.sv
tb_ps2_key_top.sv

// ==== Makefile ====
# Verilator build and run for the PS/2 keyboard receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_key_top
FILELIST  ?= ps2_key.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
